// File: logic/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data word width
`define XLEN 64

// shift amount widths, full and word ops
`define SHAMT_W 6
`define SHAMT_W_WORD 5

// one iteration per result bit
`define ITER_LAST (`XLEN - 1)

`endif

// File: logic/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

	typedef logic [`XLEN-1:0] u64;

	typedef enum logic [4:0] {
		ADD     = 5'd0,
		SUB     = 5'd1,
		XOR     = 5'd2,
		OR      = 5'd3,
		AND     = 5'd4,
		CPYB    = 5'd5,
		COMPARE = 5'd6,  // equality, 1 when srca == srcb
		SLT     = 5'd7,
		SLTU    = 5'd8,
		SLL     = 5'd9,
		SRL     = 5'd10,
		SRA     = 5'd11,
		MULT    = 5'd12, // low half of the product only
		DIV     = 5'd13,
		REM     = 5'd14,
		DIVU    = 5'd15,
		REMU    = 5'd16
	} alufunc_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		CALC  = 2'd1,
		FIXUP = 2'd2, // divide only
		DONE  = 2'd3
	} muldiv_state_t;

endpackage

`default_nettype wire

// File: logic/muldiv_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module muldiv_fsm
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic is_div,
	input logic count_done,
	output logic busy,
	output logic load,
	output logic step,
	output logic fixup,
	output logic done,
	output muldiv_state_t state
);
	muldiv_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (start) state_next = CALC;
			CALC: begin
				if (count_done)
					state_next = is_div ? FIXUP : DONE; // multiply has no sign step
			end
			FIXUP: state_next = DONE;
			DONE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	assign busy = (state != IDLE);
	assign load = (state == IDLE) && start; // operands captured on the start cycle
	assign step = (state == CALC);
	assign fixup = (state == FIXUP);
	assign done = (state == DONE);

	// the issuing side must hold off new work until the FSM is back in IDLE
	start_not_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

	// XLEN steps after the load cycle, then a single done cycle
	done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(load && !is_div) |-> ##(`XLEN + 1) done ##1 !done);

	div_done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(load && is_div) |-> ##(`XLEN + 2) done ##1 !done); // one more for the sign step

endmodule

`default_nettype wire

// File: logic/iter_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module iter_counter (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic enable,
	output logic count_done
);
	logic [`SHAMT_W-1:0] count; // one bit per iteration index

	always_ff @(posedge clk) begin
		if (reset || clear)
			count <= '0;
		else if (enable)
			count <= count + 1'b1;
	end

	assign count_done = (count == `SHAMT_W'(`ITER_LAST));

	// the last step must end the run, or a new load must restart it
	no_step_past_end: assert property (@(posedge clk) disable iff (reset)
		(count_done && enable && !clear) |=> (!enable || clear));

endmodule

`default_nettype wire

// File: logic/mul_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module mul_core
	import exec_pkg::*;
(
	input logic clk,
	input logic load,
	input logic step,
	input u64 srca,
	input u64 srcb,
	output u64 product
);
	u64 mcand; // shifted left every step
	u64 mplier; // shifted right, bit 0 is the current bit
	u64 acc;

	always_ff @(posedge clk) begin
		if (load) begin
			mcand <= srca;
			mplier <= srcb;
			acc <= '0;
		end
		else if (step) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand <= {mcand[`XLEN-2:0], 1'b0};
			mplier <= {1'b0, mplier[`XLEN-1:1]};
		end
	end

	// low half is the same for signed and unsigned operands
	assign product = acc;

endmodule

`default_nettype wire

// File: logic/div_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module div_core
	import exec_pkg::*;
(
	input logic clk,
	input logic load,
	input logic step,
	input logic fixup,
	input logic is_signed,
	input u64 srca,
	input u64 srcb,
	output u64 quot,
	output u64 rem
);
	u64 dvsr;
	u64 q; // dividend bits shift out the top, quotient bits in at the bottom
	u64 r;
	logic q_neg;
	logic r_neg;
	logic [`XLEN:0] trial;

	// bit XLEN set means the subtract borrowed and is restored
	assign trial = {r, q[`XLEN-1]} - {1'b0, dvsr};

	always_ff @(posedge clk) begin
		if (load) begin
			q <= (is_signed && srca[`XLEN-1]) ? -srca : srca;
			dvsr <= (is_signed && srcb[`XLEN-1]) ? -srcb : srcb;
			r <= '0;
			q_neg <= is_signed && (srca[`XLEN-1] ^ srcb[`XLEN-1]);
			r_neg <= is_signed && srca[`XLEN-1]; // remainder follows the dividend
		end
		else if (step) begin
			if (!trial[`XLEN]) begin
				r <= trial[`XLEN-1:0];
				q <= {q[`XLEN-2:0], 1'b1};
			end
			else begin
				r <= {r[`XLEN-2:0], q[`XLEN-1]};
				q <= {q[`XLEN-2:0], 1'b0};
			end
		end
		else if (fixup) begin
			if (q_neg)
				q <= -q;
			if (r_neg)
				r <= -r;
		end
	end

	// most negative / -1 lands here as magnitude 2^63 with no negation
	assign quot = q;
	assign rem = r;

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module alu
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid,
	input alufunc_t alufunc,
	input logic word_op,
	input u64 srca,
	input u64 srcb,
	output u64 result,
	output logic bubble
);
	logic is_mul;
	logic is_div_op;
	logic is_signed;
	logic div_zero;
	logic multi_op;
	logic start, busy, load, step, fixup, done;
	logic count_done;
	muldiv_state_t state;
	u64 product, quot, rem;
	u64 c;

	assign is_mul = (alufunc == MULT);
	assign is_div_op = (alufunc == DIV) || (alufunc == REM) ||
		(alufunc == DIVU) || (alufunc == REMU);
	assign is_signed = (alufunc == DIV) || (alufunc == REM);
	assign div_zero = is_div_op && (srcb == '0); // answered in one cycle
	assign multi_op = is_mul || (is_div_op && !div_zero);

	assign start = valid && multi_op && !busy;
	assign bubble = valid && multi_op && !done;

	always_comb begin
		c = '0;
		case (alufunc)
			ADD: c = srca + srcb;
			SUB: c = srca - srcb;
			XOR: c = srca ^ srcb;
			OR: c = srca | srcb;
			AND: c = srca & srcb;
			CPYB: c = srcb;
			COMPARE: c = {{(`XLEN-1){1'b0}}, (srca == srcb)};
			SLT: c = {{(`XLEN-1){1'b0}}, ($signed(srca) < $signed(srcb))};
			SLTU: c = {{(`XLEN-1){1'b0}}, (srca < srcb)};
			SLL: begin
				if (word_op)
					c = srca << srcb[`SHAMT_W_WORD-1:0];
				else
					c = srca << srcb[`SHAMT_W-1:0];
			end
			SRL: begin
				if (word_op)
					c[31:0] = srca[31:0] >> srcb[`SHAMT_W_WORD-1:0]; // low word only
				else
					c = srca >> srcb[`SHAMT_W-1:0];
			end
			SRA: begin
				if (word_op)
					c[31:0] = $signed(srca[31:0]) >>> srcb[`SHAMT_W_WORD-1:0];
				else
					c = $signed(srca) >>> srcb[`SHAMT_W-1:0];
			end
			MULT: c = product;
			DIV, DIVU: c = div_zero ? '1 : quot;
			REM, REMU: c = div_zero ? srca : rem;
			default: c = '0;
		endcase
	end

	assign result = word_op ? {{(`XLEN-32){c[31]}}, c[31:0]} : c;

	muldiv_fsm muldiv_fsm_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.is_div(is_div_op),
		.count_done(count_done),
		.busy(busy),
		.load(load),
		.step(step),
		.fixup(fixup),
		.done(done),
		.state(state)
	);

	iter_counter iter_counter_i (
		.clk(clk),
		.reset(reset),
		.clear(load),
		.enable(step),
		.count_done(count_done)
	);

	mul_core mul_core_i (
		.clk(clk),
		.load(load),
		.step(step),
		.srca(srca),
		.srcb(srcb),
		.product(product)
	);

	div_core div_core_i (
		.clk(clk),
		.load(load),
		.step(step),
		.fixup(fixup),
		.is_signed(is_signed),
		.srca(srca),
		.srcb(srcb),
		.quot(quot),
		.rem(rem)
	);

	alufunc_legal: assert property (@(posedge clk) disable iff (reset)
		valid |-> alufunc inside {ADD, SUB, XOR, OR, AND, CPYB, COMPARE, SLT, SLTU,
			SLL, SRL, SRA, MULT, DIV, REM, DIVU, REMU});

	// the issue register has to hold the operation for the whole run
	op_held_while_busy: assert property (@(posedge clk) disable iff (reset)
		(state != IDLE) |-> (valid && multi_op));

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input alufunc_t alufunc,
	input u64 srca,
	input u64 srcb,
	input logic word_op,
	output logic out_valid,
	output u64 result
);
	logic iss_valid;
	alufunc_t iss_func;
	u64 iss_a;
	u64 iss_b;
	logic iss_word;
	u64 alu_result;
	logic bubble;
	logic accept;
	logic complete;

	assign complete = iss_valid && !bubble; // slot frees on this edge
	assign in_ready = !iss_valid || !bubble;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset)
			iss_valid <= 1'b0;
		else if (accept)
			iss_valid <= 1'b1;
		else if (complete)
			iss_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			iss_func <= alufunc;
			iss_a <= srca;
			iss_b <= srcb;
			iss_word <= word_op;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= complete; // one pulse per finished op
	end

	always_ff @(posedge clk) begin
		if (complete)
			result <= alu_result;
	end

	alu alu_i (
		.clk(clk),
		.reset(reset),
		.valid(iss_valid),
		.alufunc(iss_func),
		.word_op(iss_word),
		.srca(iss_a),
		.srcb(iss_b),
		.result(alu_result),
		.bubble(bubble)
	);

endmodule

`default_nettype wire

// File: verification/exec_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module exec_checker
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_ready,
	input alufunc_t alufunc,
	input u64 srca,
	input u64 srcb,
	input logic word_op,
	input logic out_valid,
	input u64 result,
	input int test_id,
	input logic test_end,
	output int checks,
	output int errors,
	output int pending
);
	u64 exp_q[$];
	alufunc_t func_q[$];
	int time_q[$];
	logic multi_q[$];
	int cyc = 0;
	int test_checks = 0;
	int test_errors = 0;
	logic finish_due = 1'b0; // multi-cycle op let go of the issue slot

	initial begin
		checks = 0;
		errors = 0;
		pending = 0;
	end

	function automatic string test_name(int id);
		case (id)
			1: return "logic_compare";
			2: return "shifts";
			3: return "multiply";
			4: return "divide";
			5: return "divide_by_zero";
			6: return "reset_mid_op";
			default: return "setup";
		endcase
	endfunction

	function automatic logic is_divide(alufunc_t f);
		return (f == DIV) || (f == REM) || (f == DIVU) || (f == REMU);
	endfunction

	// truncating division with the RISC-V zero and overflow rules
	function automatic u64 divide(alufunc_t f, u64 a, u64 b);
		logic sgn;
		logic want_q;
		sgn = (f == DIV) || (f == REM);
		want_q = (f == DIV) || (f == DIVU);
		if (b == '0)
			return want_q ? '1 : a;
		if (sgn && a == {1'b1, 63'b0} && b == '1)
			return want_q ? a : '0;
		if (sgn)
			return want_q ? u64'($signed(a) / $signed(b)) : u64'($signed(a) % $signed(b));
		return want_q ? a / b : a % b;
	endfunction

	function automatic u64 expected_result(alufunc_t f, u64 a, u64 b, logic w);
		u64 r;
		logic [5:0] sh;
		sh = w ? {1'b0, b[4:0]} : b[5:0];
		case (f)
			ADD: r = a + b;
			SUB: r = a - b;
			XOR: r = a ^ b;
			OR: r = a | b;
			AND: r = a & b;
			CPYB: r = b;
			COMPARE: r = u64'(a == b);
			SLT: r = u64'($signed(a) < $signed(b));
			SLTU: r = u64'(a < b);
			SLL: r = a << sh;
			SRL: r = w ? ({32'b0, a[31:0]} >> sh) : (a >> sh);
			SRA: r = w ? u64'($signed({{32{a[31]}}, a[31:0]}) >>> sh) : u64'($signed(a) >>> sh);
			MULT: r = a * b;
			DIV, REM, DIVU, REMU: r = divide(f, a, b);
			default: r = '0;
		endcase
		return w ? {{32{r[31]}}, r[31:0]} : r;
	endfunction

	task automatic compare_result();
		u64 exp;
		alufunc_t f;
		int lat;
		logic multi;
		if (exp_q.size() == 0) begin
			$display("%s: out_valid with no operation outstanding", test_name(test_id));
			errors++;
			test_errors++;
		end
		else begin
			exp = exp_q.pop_front();
			f = func_q.pop_front();
			lat = cyc - time_q.pop_front();
			multi = multi_q.pop_front();
			checks++;
			test_checks++;
			if (result !== exp) begin
				$display("[ERROR] %s: %s expected %h, actual %h", test_name(test_id), f.name(),
					exp, result);
				errors++;
				test_errors++;
			end
			else if ((!multi && lat != 2) || (multi && lat < `XLEN)) begin
				$display("%s: %s result came %0d cycles after acceptance", test_name(test_id),
					f.name(), lat);
				errors++;
				test_errors++;
			end
		end
	endtask

	// oldest outstanding op is the one in the issue register
	task automatic check_ready();
		if (exp_q.size() == 0 || !multi_q[0]) begin
			if (!in_ready) begin
				$display("%s: in_ready low while the issue slot is free or finishing",
					test_name(test_id));
				errors++;
				test_errors++;
			end
		end
		else if (in_ready) begin
			finish_due = 1'b1; // its result has to follow on the next edge
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (reset) begin
			exp_q.delete(); // aborted ops never complete
			func_q.delete();
			time_q.delete();
			multi_q.delete();
			finish_due = 1'b0;
		end
		else begin
			if (finish_due && !out_valid) begin
				$display("%s: in_ready rose before the multi-cycle result", test_name(test_id));
				errors++;
				test_errors++;
			end
			finish_due = 1'b0;
			if (out_valid)
				compare_result();
			check_ready();
			if (in_valid && in_ready) begin
				exp_q.push_back(expected_result(alufunc, srca, srcb, word_op));
				func_q.push_back(alufunc);
				time_q.push_back(cyc);
				multi_q.push_back(alufunc == MULT || (is_divide(alufunc) && srcb != '0));
			end
		end
		pending = exp_q.size();
		if (test_end) begin
			$display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
				test_checks, test_errors);
			test_checks = 0;
			test_errors = 0;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_execute_stage
	import exec_pkg::*;
();
	localparam int WAIT_LIMIT = 200; // longer than any divide

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	alufunc_t alufunc;
	u64 srca;
	u64 srcb;
	logic word_op;
	logic out_valid;
	u64 result;
	int test_id;
	logic test_end;
	int checks;
	int errors;
	int pending;
	int seed = 32'h1fb7ece6;
	int amts[4] = '{0, 31, 32, 63};
	alufunc_t shift_ops[3] = '{SLL, SRL, SRA};
	alufunc_t div_ops[4] = '{DIV, REM, DIVU, REMU};

	execute_stage execute_stage_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.alufunc(alufunc),
		.srca(srca),
		.srcb(srcb),
		.word_op(word_op),
		.out_valid(out_valid),
		.result(result)
	);

	exec_checker exec_checker_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.alufunc(alufunc),
		.srca(srca),
		.srcb(srcb),
		.word_op(word_op),
		.out_valid(out_valid),
		.result(result),
		.test_id(test_id),
		.test_end(test_end),
		.checks(checks),
		.errors(errors),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic u64 rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic timed_out(string what);
		$display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// called and returns right after a rising edge
	task automatic issue(alufunc_t f, u64 a, u64 b, logic w);
		int waited;
		waited = 0;
		in_valid <= 1'b1;
		alufunc <= f;
		srca <= a;
		srcb <= b;
		word_op <= w;
		@(posedge clk);
		while (!in_ready && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (!in_ready)
			timed_out("in_ready while issuing");
		else
			in_valid <= 1'b0; // next issue in this time step overrides
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (pending != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending != 0)
			timed_out("result for an issued operation");
		else
			@(posedge clk);
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!in_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready)
			timed_out("in_ready after reset");
		else
			@(posedge clk);
	endtask

	task automatic end_test();
		drain();
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		alufunc = ADD;
		srca = '0;
		srcb = '0;
		word_op = 1'b0;
		test_id = 0;
		test_end = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		test_id <= 1; // back to back single-cycle ops
		repeat (40)
			issue(alufunc_t'(5'(rand_below(9))), rand64(), rand64(), 1'(rand_below(2)));
		end_test();

		test_id <= 2;
		for (int w = 0; w < 2; w++)
			for (int s = 0; s < 3; s++)
				foreach (amts[k])
					issue(shift_ops[s], rand64(), (rand64() << 6) | 64'(amts[k]), 1'(w));
		end_test();

		test_id <= 3;
		for (int i = 0; i < 6; i++)
			issue(MULT, rand64(), rand64(), 1'(i % 2));
		end_test();

		test_id <= 4;
		for (int i = 0; i < 10; i++)
			issue(div_ops[rand_below(4)], rand64(), (rand64() >> rand_below(64)) | 64'd1, 1'b0);
		issue(DIV, {1'b1, 63'b0}, '1, 1'b0); // overflow case
		issue(REM, {1'b1, 63'b0}, '1, 1'b0);
		issue(DIV, -64'd7, 64'd2, 1'b0);
		issue(REM, -64'd7, 64'd2, 1'b0);
		issue(DIVU, -64'd7, 64'd2, 1'b0);
		end_test();

		test_id <= 5;
		foreach (div_ops[k])
			issue(div_ops[k], rand64(), '0, 1'b0);
		end_test();

		test_id <= 6;
		issue(MULT, rand64(), rand64(), 1'b0);
		repeat (10) @(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (80) @(posedge clk); // stray out_valid would show up here
		wait_ready();
		issue(ADD, rand64(), rand64(), 1'b0);
		end_test();

		@(negedge clk);
		$display("all tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/exec_pkg.sv
logic/muldiv_fsm.sv
logic/iter_counter.sv
logic/mul_core.sv
logic/div_core.sv
logic/alu.sv
logic/execute_stage.sv
verification/exec_checker.sv
verification/tb_execute_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_execute_stage
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
